//--- logic/text_video_pkg.sv
package text_video_pkg;

	// ========================================
	// Character cell and memory words
	// ========================================
	localparam int CHAR_WIDTH = 16;
	localparam int CHAR_HEIGHT = 20;
	localparam int WORD_WIDTH = 32;
	localparam int FONT_ADDR_WIDTH = 15;

	// Attribute word layout
	localparam int ATTR_CODE_LSB = 0;
	localparam int ATTR_CODE_MSB = 9;
	localparam int ATTR_INVERT = 16;
	localparam int ATTR_FG_LSB = 24;
	localparam int ATTR_BG_LSB = 28;

	// ========================================
	// Colours
	// ========================================
	localparam int INDEX_WIDTH = 4;
	localparam int COLOR_DEPTH = 9;
	localparam int CHANNEL_WIDTH = COLOR_DEPTH / 3;

	// Fixed 16 colour palette, red in the top bits
	localparam logic [COLOR_DEPTH-1:0] PALETTE [16] = '{
		9'b000_000_000, 9'b010_001_001, 9'b001_001_011, 9'b010_010_010,
		9'b100_010_001, 9'b001_011_001, 9'b110_010_010, 9'b011_011_011,
		9'b010_011_110, 9'b110_011_001, 9'b100_100_101, 9'b011_101_001,
		9'b110_101_100, 9'b011_110_110, 9'b110_110_010, 9'b110_111_110
	};

endpackage

//--- logic/video_ifs.sv
// Scan position and look-ahead information from the raster counters
interface scan_if #(
	parameter int X_WIDTH = 10,
	parameter int CHAR_ROW_WIDTH = 5,
	parameter int ROW_WIDTH = 6
);
	logic [X_WIDTH-1:0] x;
	logic line_start;
	logic frame_start;
	logic hsync;
	logic vsync;
	logic y_visible;
	logic next_visible;
	logic [CHAR_ROW_WIDTH-1:0] next_char_row;
	logic [ROW_WIDTH-1:0] next_text_row;
	logic preload;

	modport timing (output x, line_start, frame_start, hsync, vsync, y_visible,
		next_visible, next_char_row, next_text_row, preload);
	modport fetch (input line_start, frame_start, preload, next_text_row);
	modport render (input line_start, next_visible, next_char_row, preload);
	modport out (input x, line_start, hsync, vsync, y_visible);
endinterface

// Row store write port, plus the end of fetch marker
interface row_wr_if #(
	parameter int INDEX_WIDTH = 7,
	parameter int DATA_WIDTH = 32
);
	logic wr_en;
	logic [INDEX_WIDTH-1:0] wr_index;
	logic [DATA_WIDTH-1:0] wr_data;
	logic fetch_done;

	modport fetcher (output wr_en, wr_index, wr_data, fetch_done);
	modport store (input wr_en, wr_index, wr_data);
	modport render (input fetch_done);
endinterface

//--- logic/raster_timing.sv
module raster_timing
	import text_video_pkg::*;
#(
	parameter int HORZ_BACK_PORCH = 248,
	parameter int HORZ_VISIBLE = 1280,
	parameter int HORZ_FRONT_PORCH = 48,
	parameter int HORZ_SYNC = 112,
	parameter int VERT_BACK_PORCH = 38,
	parameter int VERT_VISIBLE = 1024,
	parameter int VERT_FRONT_PORCH = 1,
	parameter int VERT_SYNC = 3
) (
	input logic clk,
	input logic reset,
	scan_if.timing scan
);

	localparam int HORZ_TOTAL = HORZ_BACK_PORCH + HORZ_VISIBLE + HORZ_FRONT_PORCH + HORZ_SYNC;
	localparam int VERT_TOTAL = VERT_BACK_PORCH + VERT_VISIBLE + VERT_FRONT_PORCH + VERT_SYNC;
	localparam int HORZ_SYNC_START = HORZ_BACK_PORCH + HORZ_VISIBLE + HORZ_FRONT_PORCH;
	localparam int VERT_SYNC_START = VERT_BACK_PORCH + VERT_VISIBLE + VERT_FRONT_PORCH;

	logic [$clog2(HORZ_TOTAL)-1:0] x;
	logic [$clog2(VERT_TOTAL)-1:0] y;
	int next_y;
	int next_rel;

	// ========================================
	// Pixel and line counters
	// ========================================
	always_ff @(posedge clk) begin
		if (reset) begin
			x <= '0;
			y <= '0;
		end else if (x == HORZ_TOTAL - 1) begin
			x <= '0;
			y <= (y == VERT_TOTAL - 1) ? '0 : y + 1'b1;
		end else begin
			x <= x + 1'b1;
		end
	end

	// Sync is high until the sync region, low through the end
	assign scan.x = x;
	assign scan.line_start = (x == 0);
	assign scan.frame_start = (x == 0) && (y == 0);
	assign scan.hsync = (x < HORZ_SYNC_START);
	assign scan.vsync = (y < VERT_SYNC_START);
	assign scan.y_visible = (y >= VERT_BACK_PORCH) && (y < VERT_BACK_PORCH + VERT_VISIBLE);

	// ========================================
	// Look-ahead to the following line
	// ========================================
	always_comb begin
		next_y = (y == VERT_TOTAL - 1) ? 0 : int'(y) + 1;
		next_rel = next_y - VERT_BACK_PORCH;
		scan.next_visible = (next_rel >= 0) && (next_rel < VERT_VISIBLE);
		scan.next_char_row = scan.next_visible ? $bits(scan.next_char_row)'(next_rel % CHAR_HEIGHT)
			: '0;
		scan.next_text_row = scan.next_visible ? $bits(scan.next_text_row)'(next_rel / CHAR_HEIGHT)
			: '0;
		scan.preload = scan.next_visible && (scan.next_char_row == 0);
	end

endmodule

//--- logic/row_fetcher.sv
module row_fetcher
	import text_video_pkg::*;
#(
	parameter int COLUMNS = 80
) (
	input logic clk,
	input logic reset,
	scan_if.fetch scan,
	row_wr_if.fetcher wr,
	output logic wb_cyc,
	output logic wb_stb,
	output logic [WORD_WIDTH-1:0] wb_adr,
	input logic [WORD_WIDTH-1:0] wb_dat_i,
	input logic wb_ack
);

	localparam int COL_WIDTH = (COLUMNS > 1) ? $clog2(COLUMNS) : 1;

	typedef enum logic [1:0] {IDLE, REQUEST, GAP} state_t;

	state_t state;
	logic [COL_WIDTH-1:0] column;

	assign wb_stb = wb_cyc;

	always_ff @(posedge clk) begin
		// Single-cycle strobes
		wr.wr_en <= 1'b0;
		wr.fetch_done <= 1'b0;
		if (reset) begin
			state <= IDLE;
			wb_cyc <= 1'b0;
			wb_adr <= '0;
			column <= '0;
		end else begin
			case (state)
				IDLE: begin
					if (scan.line_start && scan.preload) begin
						// Row base address, same as the running count
						wb_adr <= WORD_WIDTH'(scan.next_text_row) * WORD_WIDTH'(COLUMNS);
						column <= '0;
						wb_cyc <= 1'b1;
						state <= REQUEST;
					end else if (scan.frame_start) begin
						wb_adr <= '0;
					end
				end
				REQUEST: begin
					if (wb_ack) begin
						wr.wr_en <= 1'b1;
						wr.wr_index <= column;
						wr.wr_data <= wb_dat_i;
						wb_cyc <= 1'b0;
						wb_adr <= wb_adr + 1'b1;
						if (column == COL_WIDTH'(COLUMNS - 1)) begin
							wr.fetch_done <= 1'b1;
							state <= IDLE;
						end else begin
							column <= column + 1'b1;
							state <= GAP;
						end
					end
				end
				// Bus idle for one cycle between words
				GAP: begin
					wb_cyc <= 1'b1;
					state <= REQUEST;
				end
				default: state <= IDLE;
			endcase
		end
	end

endmodule

//--- logic/char_row_store.sv
module char_row_store
	import text_video_pkg::*;
#(
	parameter int COLUMNS = 80
) (
	input logic clk,
	row_wr_if.store wr,
	input logic [((COLUMNS > 1) ? $clog2(COLUMNS) : 1)-1:0] rd_index,
	output logic [WORD_WIDTH-1:0] rd_data
);

	// One text row of attribute words
	logic [WORD_WIDTH-1:0] mem [COLUMNS];

	always_ff @(posedge clk) begin
		if (wr.wr_en) begin
			mem[wr.wr_index] <= wr.wr_data;
		end
	end

	// Registered read
	always_ff @(posedge clk) begin
		rd_data <= mem[rd_index];
	end

endmodule

//--- logic/glyph_renderer.sv
module glyph_renderer
	import text_video_pkg::*;
#(
	parameter int COLUMNS = 80
) (
	input logic clk,
	input logic reset,
	scan_if.render scan,
	row_wr_if.render wr,
	output logic [((COLUMNS > 1) ? $clog2(COLUMNS) : 1)-1:0] rd_index,
	input logic [WORD_WIDTH-1:0] rd_data,
	output logic [FONT_ADDR_WIDTH-1:0] font_address,
	input logic [CHAR_WIDTH-1:0] font_bitmap,
	output logic px_we,
	output logic [((COLUMNS > 1) ? $clog2(COLUMNS) : 1)-1:0] px_addr,
	output logic [CHAR_WIDTH*INDEX_WIDTH-1:0] px_data
);

	localparam int COL_WIDTH = (COLUMNS > 1) ? $clog2(COLUMNS) : 1;

	// Four steps per column: read, attribute, expand, next
	typedef enum logic [2:0] {IDLE, WAIT_FETCH, READ, ATTR, EXPAND, NEXT} state_t;

	state_t state;
	logic [COL_WIDTH-1:0] column;
	logic [INDEX_WIDTH-1:0] fg;
	logic [INDEX_WIDTH-1:0] bg;
	logic [ATTR_CODE_MSB-ATTR_CODE_LSB:0] code;

	assign rd_index = column;
	assign code = rd_data[ATTR_CODE_MSB:ATTR_CODE_LSB];

	always_ff @(posedge clk) begin
		px_we <= 1'b0;
		if (reset) begin
			state <= IDLE;
			column <= '0;
		end else begin
			case (state)
				IDLE: begin
					column <= '0;
					if (scan.line_start && scan.next_visible) begin
						state <= scan.preload ? WAIT_FETCH : READ;
					end
				end
				// Row store is reloaded first on a preload line
				WAIT_FETCH: begin
					if (wr.fetch_done) begin
						state <= READ;
					end
				end
				READ: state <= ATTR;
				ATTR: begin
					// Invert swaps the two colours
					if (rd_data[ATTR_INVERT]) begin
						fg <= rd_data[ATTR_BG_LSB +: INDEX_WIDTH];
						bg <= rd_data[ATTR_FG_LSB +: INDEX_WIDTH];
					end else begin
						fg <= rd_data[ATTR_FG_LSB +: INDEX_WIDTH];
						bg <= rd_data[ATTR_BG_LSB +: INDEX_WIDTH];
					end
					font_address <= FONT_ADDR_WIDTH'(code) * FONT_ADDR_WIDTH'(CHAR_HEIGHT)
						+ FONT_ADDR_WIDTH'(scan.next_char_row);
					state <= EXPAND;
				end
				EXPAND: begin
					// Leftmost pixel is the bitmap MSB, in the low nibble
					for (int i = 0; i < CHAR_WIDTH; i++) begin
						px_data[i*INDEX_WIDTH +: INDEX_WIDTH] <=
							font_bitmap[CHAR_WIDTH-1-i] ? fg : bg;
					end
					px_addr <= column;
					px_we <= 1'b1;
					state <= NEXT;
				end
				NEXT: begin
					if (column == COL_WIDTH'(COLUMNS - 1)) begin
						state <= IDLE;
					end else begin
						column <= column + 1'b1;
						state <= READ;
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

endmodule

//--- logic/pixel_output.sv
module pixel_output
	import text_video_pkg::*;
#(
	parameter int HORZ_BACK_PORCH = 248,
	parameter int HORZ_VISIBLE = 1280
) (
	input logic clk,
	input logic reset,
	scan_if.out scan,
	input logic px_we,
	input logic [((HORZ_VISIBLE / CHAR_WIDTH > 1) ? $clog2(HORZ_VISIBLE / CHAR_WIDTH) : 1)-1:0]
		px_addr,
	input logic [CHAR_WIDTH*INDEX_WIDTH-1:0] px_data,
	output logic hsync,
	output logic vsync,
	output logic [CHANNEL_WIDTH-1:0] pixel_red,
	output logic [CHANNEL_WIDTH-1:0] pixel_green,
	output logic [CHANNEL_WIDTH-1:0] pixel_blue
);

	localparam int COLUMNS = HORZ_VISIBLE / CHAR_WIDTH;
	localparam int COL_WIDTH = (COLUMNS > 1) ? $clog2(COLUMNS) : 1;
	localparam int PX_WIDTH = CHAR_WIDTH * INDEX_WIDTH;

	logic [PX_WIDTH-1:0] line_buf [2][COLUMNS];
	logic bank;
	int rel;
	logic visible;
	logic [COL_WIDTH-1:0] rd_col;
	logic [$clog2(CHAR_WIDTH)-1:0] offset;
	logic [PX_WIDTH-1:0] rd_word;
	logic [$clog2(CHAR_WIDTH)-1:0] offset_d;
	logic visible_d;
	logic hsync_d;
	logic vsync_d;
	logic [COLOR_DEPTH-1:0] color;

	// Displayed bank flips every line, renderer fills the other
	always_ff @(posedge clk) begin
		if (reset) begin
			bank <= 1'b0;
		end else if (scan.line_start) begin
			bank <= ~bank;
		end
	end

	always_ff @(posedge clk) begin
		if (px_we) begin
			line_buf[~bank][px_addr] <= px_data;
		end
	end

	always_comb begin
		rel = int'(scan.x) - HORZ_BACK_PORCH;
		visible = scan.y_visible && (rel >= 0) && (rel < HORZ_VISIBLE);
		rd_col = visible ? COL_WIDTH'(rel / CHAR_WIDTH) : '0;
		offset = $bits(offset)'(rel % CHAR_WIDTH);
	end

	// ========================================
	// Stage 1: line buffer read
	// ========================================
	always_ff @(posedge clk) begin
		rd_word <= line_buf[bank][rd_col];
		offset_d <= offset;
		visible_d <= visible;
		hsync_d <= scan.hsync;
		vsync_d <= scan.vsync;
	end

	// ========================================
	// Stage 2: palette and blanking
	// ========================================
	assign color = PALETTE[rd_word[offset_d*INDEX_WIDTH +: INDEX_WIDTH]];

	always_ff @(posedge clk) begin
		if (reset || !visible_d) begin
			{pixel_red, pixel_green, pixel_blue} <= '0;
		end else begin
			{pixel_red, pixel_green, pixel_blue} <= color;
		end
		hsync <= hsync_d;
		vsync <= vsync_d;
	end

endmodule

//--- logic/text_video_top.sv
module text_video_top
	import text_video_pkg::*;
#(
	parameter int HORZ_BACK_PORCH = 248,
	parameter int HORZ_VISIBLE = 1280,
	parameter int HORZ_FRONT_PORCH = 48,
	parameter int HORZ_SYNC = 112,
	parameter int VERT_BACK_PORCH = 38,
	parameter int VERT_VISIBLE = 1024,
	parameter int VERT_FRONT_PORCH = 1,
	parameter int VERT_SYNC = 3
) (
	input logic clk,
	input logic reset,
	output logic hsync,
	output logic vsync,
	output logic [CHANNEL_WIDTH-1:0] pixel_red,
	output logic [CHANNEL_WIDTH-1:0] pixel_green,
	output logic [CHANNEL_WIDTH-1:0] pixel_blue,
	output logic wb_cyc,
	output logic wb_stb,
	output logic [WORD_WIDTH-1:0] wb_adr,
	input logic [WORD_WIDTH-1:0] wb_dat_i,
	input logic wb_ack,
	output logic [FONT_ADDR_WIDTH-1:0] font_address,
	input logic [CHAR_WIDTH-1:0] font_bitmap
);

	localparam int HORZ_TOTAL = HORZ_BACK_PORCH + HORZ_VISIBLE + HORZ_FRONT_PORCH + HORZ_SYNC;
	localparam int COLUMNS = HORZ_VISIBLE / CHAR_WIDTH;
	localparam int ROWS = VERT_VISIBLE / CHAR_HEIGHT;
	localparam int COL_WIDTH = (COLUMNS > 1) ? $clog2(COLUMNS) : 1;
	localparam int ROW_WIDTH = (ROWS > 1) ? $clog2(ROWS) : 1;
	localparam int PX_WIDTH = CHAR_WIDTH * INDEX_WIDTH;

	scan_if #(
		.X_WIDTH($clog2(HORZ_TOTAL)),
		.CHAR_ROW_WIDTH($clog2(CHAR_HEIGHT)),
		.ROW_WIDTH(ROW_WIDTH)
	) scan ();

	row_wr_if #(.INDEX_WIDTH(COL_WIDTH), .DATA_WIDTH(WORD_WIDTH)) row_wr ();

	logic [COL_WIDTH-1:0] rd_index;
	logic [WORD_WIDTH-1:0] rd_data;
	logic px_we;
	logic [COL_WIDTH-1:0] px_addr;
	logic [PX_WIDTH-1:0] px_data;

	raster_timing #(
		.HORZ_BACK_PORCH(HORZ_BACK_PORCH), .HORZ_VISIBLE(HORZ_VISIBLE),
		.HORZ_FRONT_PORCH(HORZ_FRONT_PORCH), .HORZ_SYNC(HORZ_SYNC),
		.VERT_BACK_PORCH(VERT_BACK_PORCH), .VERT_VISIBLE(VERT_VISIBLE),
		.VERT_FRONT_PORCH(VERT_FRONT_PORCH), .VERT_SYNC(VERT_SYNC)
	) i_timing (.clk, .reset, .scan(scan.timing));

	row_fetcher #(.COLUMNS(COLUMNS)) i_fetcher (
		.clk, .reset, .scan(scan.fetch), .wr(row_wr.fetcher),
		.wb_cyc, .wb_stb, .wb_adr, .wb_dat_i, .wb_ack
	);

	char_row_store #(.COLUMNS(COLUMNS)) i_store (
		.clk, .wr(row_wr.store), .rd_index, .rd_data
	);

	glyph_renderer #(.COLUMNS(COLUMNS)) i_renderer (
		.clk, .reset, .scan(scan.render), .wr(row_wr.render),
		.rd_index, .rd_data, .font_address, .font_bitmap,
		.px_we, .px_addr, .px_data
	);

	pixel_output #(.HORZ_BACK_PORCH(HORZ_BACK_PORCH), .HORZ_VISIBLE(HORZ_VISIBLE)) i_output (
		.clk, .reset, .scan(scan.out), .px_we, .px_addr, .px_data,
		.hsync, .vsync, .pixel_red, .pixel_green, .pixel_blue
	);

endmodule

//--- tests/tb_models.sv
// Wishbone classic read slave over the text memory
module wb_text_memory #(
	parameter int DEPTH = 8,
	parameter int SEED = 1
) (
	input logic clk,
	input logic reset,
	input logic cyc,
	input logic stb,
	input logic [31:0] adr,
	output logic [31:0] dat,
	output logic ack,
	input logic [31:0] words [DEPTH]
);

	int seed;
	int wait_left;

	initial begin
		seed = SEED;
		wait_left = 0;
		dat = '0;
		ack = 1'b0;
	end

	always @(posedge clk) begin
		ack <= 1'b0;
		if (reset) begin
			wait_left <= 0;
		end else if (cyc && stb && !ack) begin
			if (wait_left == 0) begin
				ack <= 1'b1;
				dat <= words[adr % DEPTH];
				// Stall before the next word, 0 to 3 cycles
				wait_left <= $unsigned($random(seed)) % 4;
			end else begin
				wait_left <= wait_left - 1;
			end
		end
	end

endmodule

// Font ROM, bitmap follows the registered address within the cycle
module font_rom (
	input logic [14:0] address,
	output logic [15:0] bitmap
);

	assign bitmap = 16'(address * 16'h2f1b) ^ 16'ha5c3;

endmodule

//--- tests/text_video_tb.sv
module text_video_tb
	import text_video_pkg::*;
();

	localparam int HORZ_BACK_PORCH = 8;
	localparam int HORZ_VISIBLE = 64;
	localparam int HORZ_FRONT_PORCH = 4;
	localparam int HORZ_SYNC = 8;
	localparam int VERT_BACK_PORCH = 2;
	localparam int VERT_VISIBLE = 40;
	localparam int VERT_FRONT_PORCH = 1;
	localparam int VERT_SYNC = 2;

	localparam int HORZ_SYNC_START = HORZ_BACK_PORCH + HORZ_VISIBLE + HORZ_FRONT_PORCH;
	localparam int HORZ_TOTAL = HORZ_SYNC_START + HORZ_SYNC;
	localparam int VERT_SYNC_START = VERT_BACK_PORCH + VERT_VISIBLE + VERT_FRONT_PORCH;
	localparam int VERT_TOTAL = VERT_SYNC_START + VERT_SYNC;
	localparam int COLUMNS = HORZ_VISIBLE / CHAR_WIDTH;
	localparam int ROWS = VERT_VISIBLE / CHAR_HEIGHT;
	localparam int FRAMES = 3;
	localparam int TIMEOUT_CYCLES = 4 * HORZ_TOTAL * VERT_TOTAL + 100;
	localparam int SEED = 32'he795;

	logic clk;
	logic reset;
	logic hsync;
	logic vsync;
	logic [CHANNEL_WIDTH-1:0] pixel_red;
	logic [CHANNEL_WIDTH-1:0] pixel_green;
	logic [CHANNEL_WIDTH-1:0] pixel_blue;
	logic wb_cyc;
	logic wb_stb;
	logic [31:0] wb_adr;
	logic [31:0] wb_dat_i;
	logic wb_ack;
	logic [14:0] font_address;
	logic [15:0] font_bitmap;
	logic [31:0] text_mem [ROWS*COLUMNS];

	int seed;
	int checks = 0;
	int errors = 0;
	int reads = 0;
	int frame_count = 0;
	int cycles = 0;

	// Scan model and its two cycle delay line
	int mx = 0;
	int my = 0;
	int x_d1 = 0;
	int y_d1 = 0;
	int x_d2 = 0;
	int y_d2 = 0;
	logic counting = 1'b0;
	logic valid_d1 = 1'b0;
	logic valid_d2 = 1'b0;

	text_video_top #(
		.HORZ_BACK_PORCH(HORZ_BACK_PORCH), .HORZ_VISIBLE(HORZ_VISIBLE),
		.HORZ_FRONT_PORCH(HORZ_FRONT_PORCH), .HORZ_SYNC(HORZ_SYNC),
		.VERT_BACK_PORCH(VERT_BACK_PORCH), .VERT_VISIBLE(VERT_VISIBLE),
		.VERT_FRONT_PORCH(VERT_FRONT_PORCH), .VERT_SYNC(VERT_SYNC)
	) i_dut (
		.clk, .reset, .hsync, .vsync, .pixel_red, .pixel_green, .pixel_blue,
		.wb_cyc, .wb_stb, .wb_adr, .wb_dat_i, .wb_ack, .font_address, .font_bitmap
	);

	wb_text_memory #(.DEPTH(ROWS * COLUMNS), .SEED(SEED)) i_memory (
		.clk, .reset, .cyc(wb_cyc), .stb(wb_stb), .adr(wb_adr),
		.dat(wb_dat_i), .ack(wb_ack), .words(text_mem)
	);

	font_rom i_font (.address(font_address), .bitmap(font_bitmap));

	// ========================================
	// Reference rules
	// ========================================
	function automatic logic [15:0] glyph_bits(int addr);
		logic [31:0] product;
		product = addr * 32'h2f1b;
		return product[15:0] ^ 16'ha5c3;
	endfunction

	function automatic logic [COLOR_DEPTH-1:0] expected_color(int hx, int hy);
		int px;
		int py;
		int addr;
		logic [31:0] word;
		logic [15:0] bits;
		logic [INDEX_WIDTH-1:0] fg;
		logic [INDEX_WIDTH-1:0] bg;
		px = hx - HORZ_BACK_PORCH;
		py = hy - VERT_BACK_PORCH;
		if (px < 0 || px >= HORZ_VISIBLE || py < 0 || py >= VERT_VISIBLE) begin
			return '0;
		end
		word = text_mem[(py / CHAR_HEIGHT) * COLUMNS + px / CHAR_WIDTH];
		addr = word[ATTR_CODE_MSB:ATTR_CODE_LSB] * CHAR_HEIGHT + py % CHAR_HEIGHT;
		bits = glyph_bits(addr);
		fg = word[ATTR_FG_LSB +: INDEX_WIDTH];
		bg = word[ATTR_BG_LSB +: INDEX_WIDTH];
		if (word[ATTR_INVERT]) begin
			fg = word[ATTR_BG_LSB +: INDEX_WIDTH];
			bg = word[ATTR_FG_LSB +: INDEX_WIDTH];
		end
		return PALETTE[bits[CHAR_WIDTH - 1 - px % CHAR_WIDTH] ? fg : bg];
	endfunction

	task automatic check_value(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("Fail %s: got %h, expected %h at %0t", name, actual, expected, $time);
		end
	endtask

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// ========================================
	// Scan model, aligned to reset
	// ========================================
	always @(posedge clk) begin
		if (reset) begin
			mx <= 0;
			my <= 0;
			counting <= 1'b1;
		end else if (mx == HORZ_TOTAL - 1) begin
			mx <= 0;
			my <= (my == VERT_TOTAL - 1) ? 0 : my + 1;
		end else begin
			mx <= mx + 1;
		end
		x_d1 <= mx;
		y_d1 <= my;
		valid_d1 <= counting;
		x_d2 <= x_d1;
		y_d2 <= y_d1;
		valid_d2 <= valid_d1;
	end

	// Outputs are stable away from the rising edge
	always @(negedge clk) begin
		if (reset) begin
			check_value("pixel_rgb", {pixel_red, pixel_green, pixel_blue}, '0);
			check_value("wb_cyc", wb_cyc, 1'b0);
			check_value("wb_stb", wb_stb, 1'b0);
		end else if (valid_d2) begin
			check_value("hsync", hsync, x_d2 < HORZ_SYNC_START);
			check_value("vsync", vsync, y_d2 < VERT_SYNC_START);
			check_value("pixel_rgb", {pixel_red, pixel_green, pixel_blue},
				expected_color(x_d2, y_d2));
		end
		// Accepted read at the coming edge
		if (!reset && wb_cyc && wb_stb && wb_ack) begin
			check_value("wb_adr", wb_adr, reads);
			reads++;
		end
		if (!reset && mx == 0 && my == 0) begin
			if (frame_count > 0) begin
				check_value("reads_per_frame", reads, ROWS * COLUMNS);
			end
			reads = 0;
			frame_count++;
		end
	end

	// ========================================
	// Stimulus and final report
	// ========================================
	initial begin
		reset = 1'b1;
		seed = SEED;
		for (int i = 0; i < ROWS * COLUMNS; i++) begin
			text_mem[i] = $random(seed);
		end
		repeat (2) @(posedge clk);
		reset <= 1'b0;
		while (frame_count <= FRAMES && cycles < TIMEOUT_CYCLES) begin
			@(posedge clk);
			cycles++;
		end
		if (cycles >= TIMEOUT_CYCLES) begin
			$display("Timeout after %0d cycles, only %0d frames started", cycles, frame_count);
		end
		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0 && cycles < TIMEOUT_CYCLES) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	end

endmodule

//--- verilog.f
logic/text_video_pkg.sv
logic/video_ifs.sv
logic/raster_timing.sv
logic/row_fetcher.sv
logic/char_row_store.sv
logic/glyph_renderer.sv
logic/pixel_output.sv
logic/text_video_top.sv
tests/tb_models.sv
tests/text_video_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP ?= text_video_tb
FILELIST ?= verilog.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing -Wno-fatal
PASS_TEXT ?= All tests passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the simulation, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_TEXT)" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
